//--- verilog/transmit_pkg.sv
// transmit path shared definitions
// sample type, source select encoding and the register address map
`default_nettype none

package transmit_pkg;

  localparam int SAMPLE_WIDTH = 16;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // per-channel source choice, value 3 is illegal
  typedef enum logic [1:0] {
    SRC_ZERO = 2'd0,
    SRC_AWG  = 2'd1,
    SRC_TRI  = 2'd2
  } src_sel_t;

  // register port widths
  localparam int REG_ADDR_WIDTH = 8;
  localparam int REG_DATA_WIDTH = 32;

  // per-channel bases, add the channel number
  localparam logic [REG_ADDR_WIDTH-1:0] REG_PHASE_INC_BASE = 8'h00;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_SCALE_BASE     = 8'h10;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_SRC_SEL_BASE   = 8'h20;

  // global registers
  localparam logic [REG_ADDR_WIDTH-1:0] REG_TRIG_MASK = 8'h30;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_AWG_DEPTH = 8'h31;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_AWG_CTRL  = 8'h32;

  // sample in [15:0], memory index in [23:16], channel in [27:24]
  localparam logic [REG_ADDR_WIDTH-1:0] REG_AWG_DATA  = 8'h40;

endpackage

`default_nettype wire

//--- verilog/tx_cfg_if.sv
// decoded transmit configuration
// carries per-channel and global settings from the register block to the datapath
`timescale 1ns/1ps
`default_nettype none

interface tx_cfg_if import transmit_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int AWG_DEPTH = 64,
  parameter int PHASE_BITS = 32,
  parameter int SCALE_WIDTH = 18,
  parameter int SCALE_FRAC_BITS = 16
) ();

  // channel field and index field of REG_AWG_DATA bound these
  if (CHANNELS > 16 || AWG_DEPTH > 256 || SCALE_FRAC_BITS >= SCALE_WIDTH) begin : g_bad_params
    $error("tx_cfg_if: parameters outside the register map range");
  end

  // per channel
  logic [CHANNELS-1:0][PHASE_BITS-1:0]  phase_inc;
  logic [CHANNELS-1:0]                  phase_clear;
  logic [CHANNELS-1:0][SCALE_WIDTH-1:0] scale;
  src_sel_t [CHANNELS-1:0]              src_sel;

  // global
  logic [CHANNELS-1:0]          trig_mask;
  logic [$clog2(AWG_DEPTH):0]   awg_depth;
  logic                         awg_run;

  // waveform memory write, one-cycle strobe
  logic                         awg_wr;
  logic [3:0]                   awg_wr_chan;
  logic [$clog2(AWG_DEPTH)-1:0] awg_wr_index;
  sample_t                      awg_wr_sample;

  modport regs (
    output phase_inc, phase_clear, scale, src_sel, trig_mask, awg_depth, awg_run,
    output awg_wr, awg_wr_chan, awg_wr_index, awg_wr_sample
  );

  modport awg (
    input awg_run, awg_depth, awg_wr, awg_wr_chan, awg_wr_index, awg_wr_sample
  );

  modport tri_src (input phase_inc, phase_clear);

  modport out (input scale, src_sel, trig_mask);

endinterface

`default_nettype wire

//--- verilog/transmit_regs.sv
// transmit register block
// turns single-cycle write strobes into channel config and AWG memory writes
`timescale 1ns/1ps
`default_nettype none

module transmit_regs import transmit_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int AWG_DEPTH = 64,
  parameter int PHASE_BITS = 32,
  parameter int SCALE_WIDTH = 18
) (
  input wire                       dac_clk,
  input wire                       ps_reset,
  input wire                       reg_wr,
  input wire [REG_ADDR_WIDTH-1:0]  reg_addr,
  input wire [REG_DATA_WIDTH-1:0]  reg_wdata,
  tx_cfg_if.regs                   cfg
);

  localparam int IDX_BITS = $clog2(AWG_DEPTH);
  localparam int DEPTH_BITS = IDX_BITS + 1;

  logic awg_data_wr;
  logic src_sel_wr;

  assign awg_data_wr = reg_wr && (reg_addr == REG_AWG_DATA);
  assign src_sel_wr = reg_wr && (reg_addr >= REG_SRC_SEL_BASE)
                      && (reg_addr < REG_ADDR_WIDTH'(REG_SRC_SEL_BASE + CHANNELS));

  always_ff @(posedge dac_clk) begin
    if (ps_reset) begin
      cfg.phase_inc <= '0;
      cfg.phase_clear <= '0;
      cfg.scale <= '0;
      for (int c = 0; c < CHANNELS; c++) begin
        cfg.src_sel[c] <= SRC_ZERO;
      end
      cfg.trig_mask <= '0;
      cfg.awg_depth <= '0;
      cfg.awg_run <= 1'b0;
      cfg.awg_wr <= 1'b0;
    end else begin
      // strobes only last one cycle
      cfg.phase_clear <= '0;
      cfg.awg_wr <= awg_data_wr;
      if (reg_wr) begin
        for (int c = 0; c < CHANNELS; c++) begin
          // new increment restarts that channel's phase
          if (reg_addr == REG_ADDR_WIDTH'(REG_PHASE_INC_BASE + c)) begin
            cfg.phase_inc[c] <= reg_wdata[PHASE_BITS-1:0];
            cfg.phase_clear[c] <= 1'b1;
          end
          if (reg_addr == REG_ADDR_WIDTH'(REG_SCALE_BASE + c)) begin
            cfg.scale[c] <= reg_wdata[SCALE_WIDTH-1:0];
          end
          if (reg_addr == REG_ADDR_WIDTH'(REG_SRC_SEL_BASE + c)) begin
            cfg.src_sel[c] <= src_sel_t'(reg_wdata[1:0]);
          end
        end
        case (reg_addr)
          REG_TRIG_MASK: cfg.trig_mask <= reg_wdata[CHANNELS-1:0];
          REG_AWG_DEPTH: cfg.awg_depth <= reg_wdata[DEPTH_BITS-1:0];
          REG_AWG_CTRL:  cfg.awg_run <= reg_wdata[0];
          default: ;
        endcase
      end
    end
  end

  // sample write fields, qualified by awg_wr
  always_ff @(posedge dac_clk) begin
    if (awg_data_wr) begin
      cfg.awg_wr_chan <= reg_wdata[27:24];
      cfg.awg_wr_index <= reg_wdata[16 +: IDX_BITS];
      cfg.awg_wr_sample <= sample_t'(reg_wdata[SAMPLE_WIDTH-1:0]);
    end
  end

  a_src_sel_legal: assert property (@(posedge dac_clk) disable iff (ps_reset)
    src_sel_wr |-> reg_wdata[1:0] != 2'd3)
    else $error("transmit_regs: illegal source select written");

  a_awg_chan_range: assert property (@(posedge dac_clk) disable iff (ps_reset)
    awg_data_wr |-> int'(reg_wdata[27:24]) < CHANNELS)
    else $error("transmit_regs: AWG write names a missing channel");

endmodule

`default_nettype wire

//--- verilog/awg_player.sv
// arbitrary waveform player
// one sample memory per channel, played in a loop with a frame-start marker
`timescale 1ns/1ps
`default_nettype none

module awg_player import transmit_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int AWG_DEPTH = 64
) (
  input wire            dac_clk,
  input wire            ps_reset,
  tx_cfg_if.awg         cfg,
  output sample_t       awg_sample [CHANNELS],
  output logic [CHANNELS-1:0] awg_frame_start
);

  localparam int IDX_BITS = $clog2(AWG_DEPTH);

  sample_t mem [CHANNELS][AWG_DEPTH];

  logic [IDX_BITS-1:0] rd_index;
  logic                last_index;

  // frame end, awg_depth counts samples
  assign last_index = {1'b0, rd_index} == cfg.awg_depth - 1'b1;

  // shared read index, parked at 0 while stopped
  always_ff @(posedge dac_clk) begin
    if (ps_reset) begin
      rd_index <= '0;
      awg_frame_start <= '0;
    end else begin
      if (!cfg.awg_run || last_index) begin
        rd_index <= '0;
      end else begin
        rd_index <= rd_index + 1'b1;
      end
      // marker lines up with the registered read below
      awg_frame_start <= {CHANNELS{cfg.awg_run && rd_index == '0}};
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (cfg.awg_wr && cfg.awg_wr_chan == 4'(c)) begin
        mem[c][cfg.awg_wr_index] <= cfg.awg_wr_sample;
      end
      awg_sample[c] <= mem[c][rd_index];
    end
  end

  // a stopped frame length would leave the index running off the memory
  a_depth_valid: assert property (@(posedge dac_clk) disable iff (ps_reset)
    cfg.awg_run |-> (cfg.awg_depth != '0) && (int'(cfg.awg_depth) <= AWG_DEPTH))
    else $error("awg_player: run with frame depth out of range");

endmodule

`default_nettype wire

//--- verilog/tri_gen.sv
// triangle wave source
// phase accumulator per channel, folded into a signed triangle sample
`timescale 1ns/1ps
`default_nettype none

module tri_gen import transmit_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int PHASE_BITS = 32
) (
  input wire         dac_clk,
  input wire         ps_reset,
  tx_cfg_if.tri_src  cfg,
  output sample_t    tri_sample [CHANNELS]
);

  logic [CHANNELS-1:0][PHASE_BITS-1:0] phase;

  // top bit picks the half, falling half counts down
  function automatic sample_t fold(input logic [PHASE_BITS-1:0] p);
    logic [SAMPLE_WIDTH-1:0] mag;
    mag = p[PHASE_BITS-2 -: SAMPLE_WIDTH];
    if (p[PHASE_BITS-1]) begin
      mag = ~mag;
    end
    // offset binary to two's complement
    return sample_t'({~mag[SAMPLE_WIDTH-1], mag[SAMPLE_WIDTH-2:0]});
  endfunction

  always_ff @(posedge dac_clk) begin
    if (ps_reset) begin
      phase <= '0;
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (cfg.phase_clear[c]) begin
          phase[c] <= '0;
        end else begin
          phase[c] <= phase[c] + cfg.phase_inc[c];
        end
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      tri_sample[c] <= fold(phase[c]);
    end
  end

endmodule

`default_nettype wire

//--- verilog/channel_output.sv
// channel output stage
// source select, fixed-point scaling with saturation, and trigger combining
`timescale 1ns/1ps
`default_nettype none

module channel_output import transmit_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int SCALE_WIDTH = 18,
  parameter int SCALE_FRAC_BITS = 16
) (
  input wire                          dac_clk,
  input wire                          ps_reset,
  tx_cfg_if.out                       cfg,
  input wire sample_t                 awg_sample [CHANNELS],
  input wire [CHANNELS-1:0]           awg_frame_start,
  input wire sample_t                 tri_sample [CHANNELS],
  output logic [CHANNELS*SAMPLE_WIDTH-1:0] dac_data,
  output logic                        dac_trigger_out
);

  localparam int PROD_WIDTH = SAMPLE_WIDTH + SCALE_WIDTH;
  localparam logic signed [PROD_WIDTH-1:0] SAT_MAX = PROD_WIDTH'((1 << (SAMPLE_WIDTH-1)) - 1);
  localparam logic signed [PROD_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

  sample_t             picked [CHANNELS];
  logic [CHANNELS-1:0] awg_selected;

  // arithmetic shift floors the product
  function automatic sample_t scale_sat(input sample_t s, input logic signed [SCALE_WIDTH-1:0] k);
    logic signed [PROD_WIDTH-1:0] prod;
    logic signed [PROD_WIDTH-1:0] shifted;
    prod = s * k;
    shifted = prod >>> SCALE_FRAC_BITS;
    if (shifted > SAT_MAX) begin
      return sample_t'(SAT_MAX[SAMPLE_WIDTH-1:0]);
    end else if (shifted < SAT_MIN) begin
      return sample_t'(SAT_MIN[SAMPLE_WIDTH-1:0]);
    end
    return sample_t'(shifted[SAMPLE_WIDTH-1:0]);
  endfunction

  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      awg_selected[c] = cfg.src_sel[c] == SRC_AWG;
      case (cfg.src_sel[c])
        SRC_AWG: picked[c] = awg_sample[c];
        SRC_TRI: picked[c] = tri_sample[c];
        default: picked[c] = '0;
      endcase
    end
  end

  always_ff @(posedge dac_clk) begin
    if (ps_reset) begin
      dac_data <= '0;
      dac_trigger_out <= 1'b0;
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        dac_data[c*SAMPLE_WIDTH +: SAMPLE_WIDTH] <= scale_sat(picked[c], $signed(cfg.scale[c]));
      end
      // only channels actually playing the AWG may trigger
      dac_trigger_out <= |(awg_frame_start & cfg.trig_mask & awg_selected);
    end
  end

  for (genvar c = 0; c < CHANNELS; c++) begin : g_sel_check
    a_src_sel_legal: assert property (@(posedge dac_clk) disable iff (ps_reset)
      cfg.src_sel[c] != 2'd3)
      else $error("channel_output: channel %0d has illegal source select", c);
  end

endmodule

`default_nettype wire

//--- verilog/transmit_top.sv
// multichannel DAC transmit path
// register-configured AWG and triangle sources feeding a scaled output stage
`timescale 1ns/1ps
`default_nettype none

module transmit_top import transmit_pkg::*; #(
  parameter int CHANNELS = 2,
  parameter int AWG_DEPTH = 64,
  parameter int PHASE_BITS = 32,
  parameter int SCALE_WIDTH = 18,
  parameter int SCALE_FRAC_BITS = 16
) (
  input wire                               dac_clk,
  input wire                               ps_reset,
  input wire                               reg_wr,
  input wire [REG_ADDR_WIDTH-1:0]          reg_addr,
  input wire [REG_DATA_WIDTH-1:0]          reg_wdata,
  output logic [CHANNELS*SAMPLE_WIDTH-1:0] dac_data,
  output logic                             dac_trigger_out
);

  sample_t             awg_sample [CHANNELS];
  logic [CHANNELS-1:0] awg_frame_start;
  sample_t             tri_sample [CHANNELS];

  tx_cfg_if #(
    .CHANNELS(CHANNELS),
    .AWG_DEPTH(AWG_DEPTH),
    .PHASE_BITS(PHASE_BITS),
    .SCALE_WIDTH(SCALE_WIDTH),
    .SCALE_FRAC_BITS(SCALE_FRAC_BITS)
  ) cfg ();

  transmit_regs #(
    .CHANNELS(CHANNELS),
    .AWG_DEPTH(AWG_DEPTH),
    .PHASE_BITS(PHASE_BITS),
    .SCALE_WIDTH(SCALE_WIDTH)
  ) regs_i (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .reg_wr(reg_wr),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .cfg(cfg.regs)
  );

  awg_player #(
    .CHANNELS(CHANNELS),
    .AWG_DEPTH(AWG_DEPTH)
  ) awg_i (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .cfg(cfg.awg),
    .awg_sample(awg_sample),
    .awg_frame_start(awg_frame_start)
  );

  tri_gen #(
    .CHANNELS(CHANNELS),
    .PHASE_BITS(PHASE_BITS)
  ) tri_i (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .cfg(cfg.tri_src),
    .tri_sample(tri_sample)
  );

  channel_output #(
    .CHANNELS(CHANNELS),
    .SCALE_WIDTH(SCALE_WIDTH),
    .SCALE_FRAC_BITS(SCALE_FRAC_BITS)
  ) out_i (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .cfg(cfg.out),
    .awg_sample(awg_sample),
    .awg_frame_start(awg_frame_start),
    .tri_sample(tri_sample),
    .dac_data(dac_data),
    .dac_trigger_out(dac_trigger_out)
  );

endmodule

`default_nettype wire

//--- sim/transmit_top_tb.sv
// testbench for the multichannel DAC transmit path
// table-driven AWG playback, scaling, trigger mask, triangle and zero source checks
`timescale 1ns/1ps
`default_nettype none

module transmit_top_tb import transmit_pkg::*; ();

  localparam int CHANNELS = 2;
  localparam int AWG_DEPTH = 64;
  localparam int SCALE_FRAC_BITS = 16;
  localparam int ONE = 1 << SCALE_FRAC_BITS;
  localparam logic [31:0] SEED = 32'h54e0_d35f;

  // expected behavior of a table row
  localparam int TAG_PLAY = 0;
  localparam int TAG_NO_MASK = 1;
  localparam int TAG_NOT_AWG = 2;
  localparam int NUM_ROWS = 7;

  typedef struct packed {
    int chan;
    int scale;
    int depth;
    int tag;
  } row_t;

  // 131071 is the largest factor below 2.0 that fits the 18-bit scale
  row_t rows [NUM_ROWS] = '{
    '{0, ONE, 8, TAG_PLAY},
    '{1, 131071, 12, TAG_PLAY},
    '{0, ONE / 2, 5, TAG_PLAY},
    '{1, -ONE, 16, TAG_PLAY},
    '{0, -2 * ONE, 10, TAG_PLAY},
    '{0, ONE, 6, TAG_NO_MASK},
    '{1, ONE, 7, TAG_NOT_AWG}
  };

  logic                                dac_clk;
  logic                                ps_reset;
  logic                                reg_wr;
  logic [REG_ADDR_WIDTH-1:0]           reg_addr;
  logic [REG_DATA_WIDTH-1:0]           reg_wdata;
  logic [CHANNELS*SAMPLE_WIDTH-1:0]    dac_data;
  logic                                dac_trigger_out;

  logic [31:0] lfsr;
  sample_t     frame [CHANNELS][AWG_DEPTH];

  transmit_top #(
    .CHANNELS(CHANNELS),
    .AWG_DEPTH(AWG_DEPTH)
  ) DUT (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .reg_wr(reg_wr),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .dac_data(dac_data),
    .dac_trigger_out(dac_trigger_out)
  );

  always #10 dac_clk = ~dac_clk;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic next_random(output sample_t v);
    v = '0;
    for (int b = 0; b < SAMPLE_WIDTH; b++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[SAMPLE_WIDTH-2:0], lfsr[0]};
    end
  endtask

  // floor of s*k / 2^frac, clamped to the sample range
  function automatic sample_t scaled_expect(input sample_t s, input int k);
    longint p;
    p = (longint'(s) * longint'(k)) >>> SCALE_FRAC_BITS;
    if (p > 32767) begin
      p = 32767;
    end else if (p < -32768) begin
      p = -32768;
    end
    return sample_t'(p);
  endfunction

  // rising half counts up, falling half counts down, msb flipped to signed
  function automatic sample_t tri_expect(input logic [31:0] phase);
    logic [15:0] mag;
    mag = phase[30:15];
    if (phase[31]) begin
      mag = ~mag;
    end
    return sample_t'({~mag[15], mag[14:0]});
  endfunction

  function automatic sample_t chan_data(input int ch);
    return sample_t'(dac_data[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
  endfunction

  task automatic stop_on_failure();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge dac_clk);
    reg_wr = 1'b1;
    reg_addr = addr;
    reg_wdata = data;
    @(negedge dac_clk);
    reg_wr = 1'b0;
  endtask

  task automatic wait_trigger(input int ch, input int limit);
    int n;
    n = 0;
    while (dac_trigger_out !== 1'b1 && n < limit) begin
      @(negedge dac_clk);
      n++;
    end
    if (dac_trigger_out !== 1'b1) begin
      $display("timeout: no trigger from channel %0d within %0d cycles", ch, limit);
      stop_on_failure();
    end
  endtask

  // two full frames plus the wrap back to sample 0
  task automatic check_playback(input int ch, input int k, input int depth);
    int idx;
    wait_trigger(ch, 4 * depth + 16);
    for (int i = 0; i <= 2 * depth; i++) begin
      idx = i % depth;
      check_value($sformatf("dac_data[%0d]", ch), chan_data(ch),
                  scaled_expect(frame[ch][idx], k));
      check_value("dac_trigger_out", dac_trigger_out, idx == 0);
      @(negedge dac_clk);
    end
  endtask

  task automatic check_no_trigger(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge dac_clk);
      check_value("dac_trigger_out", dac_trigger_out, 0);
    end
  endtask

  task automatic run_row(input row_t r);
    sample_t s;
    int      ch;
    ch = r.chan;
    write_reg(REG_AWG_CTRL, 32'd0);
    write_reg(REG_AWG_DEPTH, 32'(r.depth));
    for (int i = 0; i < r.depth; i++) begin
      next_random(s);
      frame[ch][i] = s;
      write_reg(REG_AWG_DATA, {4'h0, 4'(ch), 8'(i), s});
    end
    write_reg(REG_SCALE_BASE + 8'(ch), 32'(r.scale));
    write_reg(REG_SRC_SEL_BASE + 8'(ch), (r.tag == TAG_NOT_AWG) ? 32'(SRC_TRI) : 32'(SRC_AWG));
    write_reg(REG_TRIG_MASK, (r.tag == TAG_NO_MASK) ? 32'd0 : 32'(1 << ch));
    write_reg(REG_AWG_CTRL, 32'd1);
    if (r.tag == TAG_PLAY) begin
      check_playback(ch, r.scale, r.depth);
    end else begin
      check_no_trigger(2 * r.depth + 4);
    end
  endtask

  // triangle on ch while the other channel is switched to zero mid-stream
  task automatic check_triangle(input int ch, input int other, input logic [31:0] inc);
    logic [31:0] phase;
    write_reg(REG_SCALE_BASE + 8'(ch), 32'(ONE));
    write_reg(REG_SRC_SEL_BASE + 8'(ch), 32'(SRC_TRI));
    write_reg(REG_PHASE_INC_BASE + 8'(ch), inc);
    // phase write took effect one edge ago, sample 0 arrives three edges after it
    repeat (3) @(negedge dac_clk);
    phase = '0;
    for (int k = 0; k < 240; k++) begin
      check_value($sformatf("dac_data[%0d]", ch), chan_data(ch), tri_expect(phase));
      if (k >= 202) begin
        check_value($sformatf("dac_data[%0d]", other), chan_data(other), 0);
      end
      phase = phase + inc;
      if (k == 200) begin
        reg_wr = 1'b1;
        reg_addr = REG_SRC_SEL_BASE + 8'(other);
        reg_wdata = 32'(SRC_ZERO);
      end
      if (k == 201) begin
        reg_wr = 1'b0;
      end
      @(negedge dac_clk);
    end
  endtask

  initial begin
    dac_clk = 1'b0;
    ps_reset = 1'b1;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    lfsr = SEED;
    repeat (10) @(negedge dac_clk);
    ps_reset = 1'b0;

    for (int i = 0; i < 20; i++) begin
      @(negedge dac_clk);
      check_value("dac_data", dac_data, 0);
      check_value("dac_trigger_out", dac_trigger_out, 0);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end

    check_triangle(0, 1, 32'h0123_4567);

    // every failing check has already stopped the run
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/transmit_pkg.sv
verilog/tx_cfg_if.sv
verilog/transmit_regs.sv
verilog/awg_player.sv
verilog/tri_gen.sv
verilog/channel_output.sv
verilog/transmit_top.sv
sim/transmit_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the transmit path testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module transmit_top_tb -Mdir "$BUILD_DIR" -o transmit_top_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/transmit_top_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
